// ==== hw/spi_bridge_pkg.sv ====
package spi_bridge_pkg;

    localparam int REG_ADDR_W = 4;                      // register address width
    localparam int REG_DATA_W = 8;                      // register data width
    localparam int REG_COUNT  = 1 << REG_ADDR_W;        // 16 registers

    // returned on the first byte, the read turnaround byte and nop frames
    localparam logic [REG_DATA_W-1:0] TURNAROUND_BYTE = 8'h00;

    // command byte bits 7:6
    typedef enum logic [1:0] {
        OP_NOP   = 2'b00,                               // no operation
        OP_WRITE = 2'b01,                               // burst write
        OP_READ  = 2'b10,                               // burst read with turnaround
        OP_RSVD  = 2'b11                                // handled like nop
    } spi_opcode_e;

    typedef struct packed {
        logic                  valid;                   // one-cycle strobe
        logic [REG_DATA_W-1:0] data;                    // received byte
    } spi_byte_t;

    typedef struct packed {
        logic                  valid;                   // one-cycle command strobe
        logic                  we;                      // 1 = write
        logic [REG_ADDR_W-1:0] adr;                     // register address
        logic [REG_DATA_W-1:0] dat;                     // write data
    } reg_cmd_t;

    typedef struct packed {
        logic                  done;                    // one-cycle completion strobe
        logic [REG_DATA_W-1:0] dat;                     // read data
    } reg_rsp_t;

    typedef struct packed {
        logic                  cyc;                     // bus cycle
        logic                  stb;                     // strobe
        logic                  we;                      // write enable
        logic [REG_ADDR_W-1:0] adr;                     // address
        logic [REG_DATA_W-1:0] dat;                     // write data
    } wb_m2s_t;

    typedef struct packed {
        logic                  ack;                     // acknowledge
        logic [REG_DATA_W-1:0] dat;                     // read data
    } wb_s2m_t;

endpackage

// ==== hw/spi_target.sv ====
module spi_target (
    input  logic                                    clk,
    input  logic                                    reset_i,
    input  logic                                    spi_sck_i,      // spi clock pin
    input  logic                                    spi_copi_i,     // data from initiator
    input  logic                                    spi_cs_i,       // chip select, active low
    output logic                                    spi_cipo_o,     // data to initiator
    output spi_bridge_pkg::spi_byte_t               rx_byte_o,      // received byte event
    output logic                                    tx_load_o,      // tx byte was just loaded
    input  logic [spi_bridge_pkg::REG_DATA_W-1:0]   tx_byte_i,      // next byte to send
    output logic                                    frame_active_o  // cs low after sync
);
    import spi_bridge_pkg::*;

    logic [1:0]            sck_sync;                    // two-flop synchronizers
    logic [1:0]            copi_sync;
    logic [1:0]            cs_sync;
    logic                  sck_prev;                    // last synced sck for edge detect
    logic                  sck_rise;
    logic                  sck_fall;
    logic [REG_DATA_W-1:0] shift_q;                     // shared rx/tx shift register
    logic [2:0]            bit_cnt;                     // bits done in current byte

    assign sck_rise       = sck_sync[1] & ~sck_prev;
    assign sck_fall       = ~sck_sync[1] & sck_prev;
    assign frame_active_o = ~cs_sync[1];
    assign spi_cipo_o     = shift_q[REG_DATA_W-1];      // msb first

    always_ff @(posedge clk) begin
        if (reset_i) begin
            sck_sync        <= 2'b00;
            copi_sync       <= 2'b00;
            cs_sync         <= 2'b11;                   // start deselected
            sck_prev        <= 1'b0;
            shift_q         <= '0;                      // keeps cipo low after reset
            bit_cnt         <= 3'd0;
            rx_byte_o.valid <= 1'b0;
            tx_load_o       <= 1'b0;
        end else begin
            sck_sync  <= {sck_sync[0], spi_sck_i};
            copi_sync <= {copi_sync[0], spi_copi_i};
            cs_sync   <= {cs_sync[0], spi_cs_i};
            sck_prev  <= sck_sync[1];

            rx_byte_o.valid <= 1'b0;                    // strobes default low
            tx_load_o       <= 1'b0;

            if (cs_sync[1]) begin                       // deselected
                tx_load_o <= 1'b1;                      // keep first byte preloaded
                shift_q   <= tx_byte_i;
                bit_cnt   <= 3'd0;
            end else if (sck_rise) begin
                // mode 0 samples copi on the rising edge
                shift_q <= {shift_q[REG_DATA_W-2:0], copi_sync[1]};
                if (bit_cnt == 3'd7) begin
                    rx_byte_o.valid <= 1'b1;            // last bit of the byte
                    rx_byte_o.data  <= {shift_q[REG_DATA_W-2:0], copi_sync[1]};
                end
            end else if (sck_fall) begin
                bit_cnt <= bit_cnt + 3'd1;              // wraps after 8 bits
                if (bit_cnt == 3'd7) begin
                    tx_load_o <= 1'b1;                  // byte boundary, reload
                    shift_q   <= tx_byte_i;
                end
            end
        end
    end

endmodule

// ==== hw/spi_cmd_decoder.sv ====
module spi_cmd_decoder (
    input  logic                                    clk,
    input  logic                                    reset_i,
    input  spi_bridge_pkg::spi_byte_t               rx_byte_i,      // byte from spi target
    input  logic                                    tx_load_i,      // tx byte consumed
    input  logic                                    frame_active_i, // cs asserted
    output logic [spi_bridge_pkg::REG_DATA_W-1:0]   tx_byte_o,      // next byte to send
    output spi_bridge_pkg::reg_cmd_t                reg_cmd_o,      // register command
    input  spi_bridge_pkg::reg_rsp_t                reg_rsp_i       // command result
);
    import spi_bridge_pkg::*;

    typedef enum logic [2:0] {
        ST_IDLE,                                        // waiting for a frame
        ST_CMD,                                         // expecting the command byte
        ST_WRITE,                                       // data bytes go to registers
        ST_READ,                                        // turnaround then register data
        ST_IGNORE                                       // nop or reserved frame
    } dec_state_e;

    dec_state_e            state;
    spi_opcode_e           opcode;
    logic [REG_ADDR_W-1:0] cur_adr;                     // current register address
    logic                  busy;                        // one command outstanding
    logic                  cmd_pend;                    // request waiting on busy
    logic                  ta_pend;                     // turnaround byte not yet sent
    logic                  buf_valid;                   // prefetch buffer full
    logic [REG_DATA_W-1:0] buf_dat;                     // prefetched read data
    logic [REG_DATA_W-1:0] wr_hold;                     // last write byte
    logic                  issue_req;
    logic [REG_ADDR_W-1:0] issue_adr;
    logic [REG_DATA_W-1:0] issue_dat;

    assign opcode = spi_opcode_e'(rx_byte_i.data[7:6]);

    // prefetched data only after turnaround, zero otherwise
    assign tx_byte_o = (state == ST_READ && !ta_pend && buf_valid) ? buf_dat : TURNAROUND_BYTE;

    always_comb begin
        issue_req = cmd_pend;                           // retry a deferred request
        issue_adr = cur_adr;
        issue_dat = wr_hold;
        case (state)
            ST_CMD: begin
                if (rx_byte_i.valid && opcode == OP_READ) begin
                    issue_req = 1'b1;                   // first prefetch right away
                    issue_adr = rx_byte_i.data[REG_ADDR_W-1:0];
                end
            end
            ST_WRITE: begin
                if (rx_byte_i.valid) begin
                    issue_req = 1'b1;
                    issue_dat = rx_byte_i.data;
                end
            end
            ST_READ: begin
                if (tx_load_i && !ta_pend) begin
                    issue_req = 1'b1;                   // buffer consumed, fetch next
                end
            end
            default: ;
        endcase
    end

    always_ff @(posedge clk) begin
        if (reset_i) begin
            state           <= ST_IDLE;
            cur_adr         <= '0;
            busy            <= 1'b0;
            cmd_pend        <= 1'b0;
            ta_pend         <= 1'b0;
            buf_valid       <= 1'b0;
            reg_cmd_o.valid <= 1'b0;
        end else begin
            reg_cmd_o.valid <= 1'b0;

            if (reg_rsp_i.done) begin
                busy    <= 1'b0;
                cur_adr <= cur_adr + 1'b1;              // wraps 15 -> 0
                if (!reg_cmd_o.we) begin
                    buf_dat   <= reg_rsp_i.dat;
                    buf_valid <= 1'b1;
                end
            end

            if (issue_req) begin
                if (!busy) begin
                    reg_cmd_o.valid <= 1'b1;
                    reg_cmd_o.we    <= (state == ST_WRITE);
                    reg_cmd_o.adr   <= issue_adr;
                    reg_cmd_o.dat   <= issue_dat;
                    busy            <= 1'b1;
                    cmd_pend        <= 1'b0;
                end else begin
                    cmd_pend <= 1'b1;                   // hold until done
                end
            end

            if (state == ST_WRITE && rx_byte_i.valid) begin
                wr_hold <= rx_byte_i.data;
            end

            case (state)
                ST_IDLE: begin
                    buf_valid <= 1'b0;
                    ta_pend   <= 1'b0;
                    if (frame_active_i && !busy) begin  // previous frame fully drained
                        state <= ST_CMD;
                    end
                end
                ST_CMD: begin
                    if (rx_byte_i.valid) begin
                        cur_adr <= rx_byte_i.data[REG_ADDR_W-1:0];
                        case (opcode)
                            OP_WRITE: state <= ST_WRITE;
                            OP_READ: begin
                                state   <= ST_READ;
                                ta_pend <= 1'b1;
                            end
                            default: state <= ST_IGNORE;
                        endcase
                    end
                end
                ST_READ: begin
                    if (tx_load_i) begin
                        if (ta_pend) begin
                            ta_pend <= 1'b0;            // turnaround went out
                        end else begin
                            buf_valid <= 1'b0;
                        end
                    end
                end
                default: ;
            endcase

            if (!frame_active_i) begin                  // cs high aborts the frame
                state    <= ST_IDLE;
                cmd_pend <= 1'b0;
            end
        end
    end

endmodule

// ==== hw/wb_initiator.sv ====
module wb_initiator (
    input  logic                        clk,
    input  logic                        reset_i,
    input  spi_bridge_pkg::reg_cmd_t    reg_cmd_i,      // command from decoder
    output spi_bridge_pkg::reg_rsp_t    reg_rsp_o,      // done pulse with read data
    output spi_bridge_pkg::wb_m2s_t     wb_o,           // wishbone initiator side
    input  spi_bridge_pkg::wb_s2m_t     wb_i            // wishbone target side
);
    import spi_bridge_pkg::*;

    typedef enum logic [1:0] {
        WB_IDLE,                                        // no cycle
        WB_BUSY,                                        // cyc/stb held until ack
        WB_DONE                                         // one-cycle done pulse
    } wb_state_e;

    wb_state_e             state;
    logic                  cmd_we;                      // registered command
    logic [REG_ADDR_W-1:0] cmd_adr;
    logic [REG_DATA_W-1:0] cmd_dat;
    logic [REG_DATA_W-1:0] rd_dat_q;                    // data captured at ack
    logic                  bus_active;

    assign bus_active = (state == WB_BUSY);

    assign wb_o = '{
        cyc: bus_active,
        stb: bus_active,                                // single beat, stb follows cyc
        we:  cmd_we,
        adr: cmd_adr,
        dat: cmd_dat
    };

    assign reg_rsp_o = '{done: (state == WB_DONE), dat: rd_dat_q};

    always_ff @(posedge clk) begin
        if (reset_i) begin
            state <= WB_IDLE;
        end else begin
            case (state)
                WB_IDLE: if (reg_cmd_i.valid) state <= WB_BUSY;
                WB_BUSY: if (wb_i.ack) state <= WB_DONE;    // cyc drops next cycle
                WB_DONE: state <= WB_IDLE;
                default: state <= WB_IDLE;
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (state == WB_IDLE && reg_cmd_i.valid) begin
            cmd_we  <= reg_cmd_i.we;
            cmd_adr <= reg_cmd_i.adr;
            cmd_dat <= reg_cmd_i.dat;
        end
        if (bus_active && wb_i.ack) begin
            rd_dat_q <= wb_i.dat;                       // don't care on writes
        end
    end

endmodule

// ==== hw/wb_reg_bank.sv ====
module wb_reg_bank (
    input  logic                        clk,
    input  logic                        reset_i,
    input  spi_bridge_pkg::wb_m2s_t     wb_i,           // from wishbone initiator
    output spi_bridge_pkg::wb_s2m_t     wb_o            // ack and read data
);
    import spi_bridge_pkg::*;

    logic [REG_DATA_W-1:0] regs [REG_COUNT];            // the register file
    logic                  ack_q;
    logic [REG_DATA_W-1:0] dat_q;                       // read data for the ack cycle
    logic                  req;                         // new access this cycle

    // cyc is still high during the ack cycle, so mask it
    assign req = wb_i.cyc & wb_i.stb & ~ack_q;

    assign wb_o = '{ack: ack_q, dat: dat_q};

    always_ff @(posedge clk) begin
        if (reset_i) begin
            ack_q <= 1'b0;
            for (int i = 0; i < REG_COUNT; i++) begin
                regs[i] <= '0;                          // registers read 0 after reset
            end
        end else begin
            ack_q <= req;                               // exactly one cycle per access
            if (req && wb_i.we) begin
                regs[wb_i.adr] <= wb_i.dat;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (req && !wb_i.we) begin
            dat_q <= regs[wb_i.adr];                    // valid with ack
        end
    end

endmodule

// ==== hw/spi_bridge_top.sv ====
module spi_bridge_top (
    input  logic clk,
    input  logic reset_i,
    input  logic spi_sck_i,                             // spi clock, at most clk/8
    input  logic spi_copi_i,                            // data from initiator
    input  logic spi_cs_i,                              // chip select, active low
    output logic spi_cipo_o                             // data to initiator
);
    import spi_bridge_pkg::*;

    spi_byte_t             rx_byte;                     // spi target -> decoder
    logic                  tx_load;
    logic [REG_DATA_W-1:0] tx_byte;                     // decoder -> spi target
    logic                  frame_active;
    reg_cmd_t              reg_cmd;                     // decoder -> wishbone initiator
    reg_rsp_t              reg_rsp;
    wb_m2s_t               wb_m2s;                      // wishbone bus
    wb_s2m_t               wb_s2m;

    spi_target i_spi_target (
        .clk            (clk),
        .reset_i        (reset_i),
        .spi_sck_i      (spi_sck_i),
        .spi_copi_i     (spi_copi_i),
        .spi_cs_i       (spi_cs_i),
        .spi_cipo_o     (spi_cipo_o),
        .rx_byte_o      (rx_byte),
        .tx_load_o      (tx_load),
        .tx_byte_i      (tx_byte),
        .frame_active_o (frame_active)
    );

    spi_cmd_decoder i_spi_cmd_decoder (
        .clk            (clk),
        .reset_i        (reset_i),
        .rx_byte_i      (rx_byte),
        .tx_load_i      (tx_load),
        .frame_active_i (frame_active),
        .tx_byte_o      (tx_byte),
        .reg_cmd_o      (reg_cmd),
        .reg_rsp_i      (reg_rsp)
    );

    wb_initiator i_wb_initiator (
        .clk            (clk),
        .reset_i        (reset_i),
        .reg_cmd_i      (reg_cmd),
        .reg_rsp_o      (reg_rsp),
        .wb_o           (wb_m2s),
        .wb_i           (wb_s2m)
    );

    wb_reg_bank i_wb_reg_bank (
        .clk            (clk),
        .reset_i        (reset_i),
        .wb_i           (wb_m2s),
        .wb_o           (wb_s2m)
    );

endmodule

// ==== tb/spi_bridge_checker.sv ====
module spi_bridge_checker (
    input  logic                                    clk,
    input  logic                                    spi_sck_i,      // pins as seen by the dut
    input  logic                                    spi_copi_i,
    input  logic                                    spi_cs_i,
    input  logic                                    spi_cipo_i,
    input  spi_bridge_pkg::spi_opcode_e             frame_op_i,     // next frame, from the driver
    input  logic [spi_bridge_pkg::REG_ADDR_W-1:0]   frame_adr_i,
    output int                                      frames_done_o,
    output int                                      failed_tests_o,
    output int                                      errors_o
);
    import spi_bridge_pkg::*;

    logic [7:0]            model [REG_COUNT];           // expected register contents
    logic                  sck_q = 1'b0;                // last sampled pins for edge detect
    logic                  cs_q  = 1'b1;
    spi_opcode_e           op;                          // latched frame parameters
    logic [REG_ADDR_W-1:0] adr;                         // model address pointer
    int                    bit_cnt;
    int                    frame_errs;
    logic [7:0]            copi_sh;                     // rebuilt bytes, msb first
    logic [7:0]            cipo_sh;

    initial begin
        for (int i = 0; i < REG_COUNT; i++) begin
            model[i] = 8'h00;                           // registers clear on reset
        end
        frames_done_o  = 0;
        failed_tests_o = 0;
        errors_o       = 0;
    end

    task automatic check_byte(input int idx, input logic [7:0] copi_b, input logic [7:0] cipo_b);
        logic [7:0] exp;
        exp = 8'h00;                                    // command, turnaround and idle bytes
        if (idx > 0 && op == OP_WRITE) begin
            model[adr] = copi_b;
            adr        = adr + REG_ADDR_W'(1);          // wraps 15 -> 0
        end else if (op == OP_READ && idx >= 2) begin
            exp = model[adr];                           // byte 1 is the turnaround
            adr = adr + REG_ADDR_W'(1);
        end
        if (cipo_b !== exp) begin
            $display("[ERROR] t=%0t spi_cipo_o byte %0d: expected %02h, got %02h",
                     $time, idx, exp, cipo_b);
            frame_errs++;
        end
    endtask

    // watch the pins and rebuild each byte
    always @(negedge clk) begin
        if (cs_q && !spi_cs_i) begin                    // frame starts
            op         = frame_op_i;
            adr        = frame_adr_i;
            bit_cnt    = 0;
            frame_errs = 0;
        end
        if (!spi_cs_i && spi_sck_i && !sck_q) begin     // mode 0 sample point
            copi_sh = {copi_sh[6:0], spi_copi_i};
            cipo_sh = {cipo_sh[6:0], spi_cipo_i};
            bit_cnt++;
            if (bit_cnt % 8 == 0) begin
                check_byte(bit_cnt / 8 - 1, copi_sh, cipo_sh);
            end
        end
        if (!cs_q && spi_cs_i) begin                    // frame ends
            $display("test %0d: %s adr %0d, %0d bits: %s", frames_done_o, op.name(), adr,
                     bit_cnt, (frame_errs == 0) ? "ok" : "FAILED");
            errors_o += frame_errs;
            if (frame_errs != 0) begin
                failed_tests_o++;
            end
            frames_done_o++;
        end
        sck_q = spi_sck_i;
        cs_q  = spi_cs_i;
    end

endmodule

// ==== tb/tb_spi_bridge.sv ====
module tb_spi_bridge;
    import spi_bridge_pkg::*;

    localparam int N_FRAMES   = 10;
    localparam int MAX_BYTES  = 18;                     // data bytes plus a partial one
    localparam int RST_CYCLES = 8;
    localparam int HALF_SCK   = 5;                      // clk cycles per sck half period

    logic clk;
    logic reset_i;
    logic spi_sck;
    logic spi_copi;
    logic spi_cs;
    logic spi_cipo;

    // stimulus table, one frame per row
    spi_opcode_e           tbl_op  [N_FRAMES];
    logic [REG_ADDR_W-1:0] tbl_adr [N_FRAMES];
    int                    tbl_len [N_FRAMES];          // bytes after the command byte
    int                    tbl_cut [N_FRAMES];          // bits of an extra byte before cs rises
    logic [7:0]            tbl_dat [N_FRAMES][MAX_BYTES];
    int                    n_rows;

    spi_opcode_e           frame_op;                    // hand-off to the checker
    logic [REG_ADDR_W-1:0] frame_adr;
    int                    frames_done;
    int                    failed_tests;
    int                    errors;

    logic [31:0]           lfsr_state;
    int                    cycle_cnt;
    int                    cycle_limit;

    always #5 clk = ~clk;                               // 10 unit period

    spi_bridge_top i_spi_bridge_top (
        .clk        (clk),
        .reset_i    (reset_i),
        .spi_sck_i  (spi_sck),
        .spi_copi_i (spi_copi),
        .spi_cs_i   (spi_cs),
        .spi_cipo_o (spi_cipo)
    );

    spi_bridge_checker i_spi_bridge_checker (
        .clk            (clk),
        .spi_sck_i      (spi_sck),
        .spi_copi_i     (spi_copi),
        .spi_cs_i       (spi_cs),
        .spi_cipo_i     (spi_cipo),
        .frame_op_i     (frame_op),
        .frame_adr_i    (frame_adr),
        .frames_done_o  (frames_done),
        .failed_tests_o (failed_tests),
        .errors_o       (errors)
    );

    function automatic logic [31:0] lfsr_step(input logic [31:0] s);
        return {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]};  // x^32 + x^22 + x^2 + x + 1
    endfunction

    function automatic logic [7:0] rand_byte();
        logic [7:0] b;
        b = 8'h00;
        for (int i = 0; i < 8; i++) begin
            lfsr_state = lfsr_step(lfsr_state);         // one step per bit
            b          = {b[6:0], lfsr_state[0]};
        end
        return b;
    endfunction

    task automatic add_frame(input spi_opcode_e op, input logic [REG_ADDR_W-1:0] adr,
                             input int len, input int cut, input bit rnd, input logic [7:0] d0);
        tbl_op[n_rows]  = op;
        tbl_adr[n_rows] = adr;
        tbl_len[n_rows] = len;
        tbl_cut[n_rows] = cut;
        for (int i = 0; i < MAX_BYTES; i++) begin
            if (rnd) begin
                tbl_dat[n_rows][i] = rand_byte();
            end else begin
                tbl_dat[n_rows][i] = (i == 0) ? d0 : 8'h00;
            end
        end
        n_rows++;
    endtask

    task automatic send_bit(input logic b);
        spi_copi <= b;                                  // copi moves while sck is low
        repeat (HALF_SCK) @(posedge clk);
        spi_sck <= 1'b1;                                // target samples here
        repeat (HALF_SCK) @(posedge clk);
        spi_sck <= 1'b0;
    endtask

    task automatic run_frame(input int e);
        logic [7:0] cmd;
        cmd = {tbl_op[e], 2'b00, tbl_adr[e]};
        frame_op  <= tbl_op[e];
        frame_adr <= tbl_adr[e];
        @(posedge clk);
        spi_cs <= 1'b0;
        repeat (HALF_SCK) @(posedge clk);
        for (int i = 7; i >= 0; i--) begin
            send_bit(cmd[i]);
        end
        for (int k = 0; k < tbl_len[e]; k++) begin
            for (int i = 7; i >= 0; i--) begin
                send_bit(tbl_dat[e][k][i]);
            end
        end
        for (int i = 0; i < tbl_cut[e]; i++) begin
            send_bit(tbl_dat[e][tbl_len[e]][7-i]);      // partial byte, aborted by cs
        end
        repeat (HALF_SCK) @(posedge clk);
        spi_cs <= 1'b1;
        repeat (4 * HALF_SCK) @(posedge clk);           // last command drains
    endtask

    always @(posedge clk) begin
        cycle_cnt <= cycle_cnt + 1;
        if (cycle_limit > 0 && cycle_cnt >= cycle_limit) begin
            $display("timeout: run still busy after %0d clk cycles", cycle_cnt);
            $display("sim failed");
            $finish;
        end
    end

    initial begin
        clk         = 1'b0;
        reset_i     = 1'b1;
        spi_sck     = 1'b0;
        spi_copi    = 1'b0;
        spi_cs      = 1'b1;                             // deselected
        frame_op    = OP_NOP;
        frame_adr   = '0;
        lfsr_state  = 32'h64ec6fe0;
        n_rows      = 0;
        cycle_cnt   = 0;
        cycle_limit = 0;

        add_frame(OP_READ,  4'd0, 17, 0, 1'b0, 8'h00);  // all registers clear after reset
        add_frame(OP_WRITE, 4'd9,  1, 0, 1'b0, 8'ha5);  // single write
        add_frame(OP_READ,  4'd9,  2, 0, 1'b0, 8'h00);  // reads it back
        add_frame(OP_WRITE, 4'd5, 16, 0, 1'b1, 8'h00);  // burst wraps to 4
        add_frame(OP_READ,  4'd5, 17, 0, 1'b0, 8'h00);
        add_frame(OP_NOP,   4'd2,  4, 0, 1'b1, 8'h00);  // data bytes must be dropped
        add_frame(OP_RSVD,  4'd7,  4, 0, 1'b1, 8'h00);
        add_frame(OP_READ,  4'd0, 17, 0, 1'b0, 8'h00);
        add_frame(OP_WRITE, 4'd3,  1, 4, 1'b0, 8'h3c);  // cs rises inside the 2nd data byte
        add_frame(OP_READ,  4'd0, 17, 0, 1'b0, 8'h00);  // fresh command byte

        for (int e = 0; e < n_rows; e++) begin
            cycle_limit += (tbl_len[e] + 1) * 8 * 2 * HALF_SCK * 2;
        end
        cycle_limit += RST_CYCLES;

        repeat (RST_CYCLES) @(posedge clk);
        reset_i <= 1'b0;
        repeat (4) @(posedge clk);

        for (int e = 0; e < n_rows; e++) begin
            run_frame(e);
        end
        wait (frames_done == n_rows);
        @(posedge clk);

        $display("summary: %0d tests run, %0d failed, %0d errors", frames_done, failed_tests,
                 errors);
        if (failed_tests == 0 && errors == 0) begin
            $display("sim passed");
        end else begin
            $display("sim failed");
        end
        $finish;
    end

endmodule

// ==== list.f ====
hw/spi_bridge_pkg.sv
hw/spi_target.sv
hw/spi_cmd_decoder.sv
hw/wb_initiator.sv
hw/wb_reg_bank.sv
hw/spi_bridge_top.sv
tb/spi_bridge_checker.sv
tb/tb_spi_bridge.sv

// ==== run.sh ====
#!/bin/sh
# build and run the spi bridge testbench with verilator
set -e

cd "$(dirname "$0")"

verilator --binary --timing \
    --top-module tb_spi_bridge \
    -f list.f \
    -o sim_tb

out=$(./obj_dir/sim_tb)
echo "$out"

if echo "$out" | grep -qx "sim passed"; then
    exit 0
fi
exit 1
